// File: bench/csa_clk_gen.sv
`timescale 1ns/1ps

module csa_clk_gen (
	input  logic rst_req_i,
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD_NS = 10;
	localparam int RESET_CYCLES = 16;

	logic por_n;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD_NS clk_o = ~clk_o;
	end

	// Power-on reset, released on a falling edge
	initial begin
		por_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		por_n = 1'b1;
	end

	assign rst_n_o = por_n && !rst_req_i;

endmodule

// File: bench/csa_search_assert.sv
`timescale 1ns/1ps

module csa_search_assert (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          in_ready_i,
	input logic                          out_valid_i,
	input logic                          out_ready_i,
	input logic [csa_job_pkg::RES_W-1:0] out_data_i
);

	// Output word holds until the host takes it
	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
		else $error("out_valid_o or its data changed before out_ready_i");

	out_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_valid_i))
		else $error("out_valid_o is unknown after reset");

	// Input queue is empty right after reset
	ready_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> in_ready_i)
		else $error("in_ready_o low in the first cycle after reset");

endmodule

// File: bench/csa_tb.sv
`timescale 1ns/1ps

module csa_tb;

	localparam int JOB_COUNT = 48;
	localparam int MAX_LATENCY = 60;
	localparam int MARGIN = 1000;

	logic clk;
	logic rst_n;
	logic rst_req;
	logic in_valid;
	logic in_ready;
	logic [31:0] in_block;
	logic [63:0] in_cw;
	logic [31:0] in_times;
	logic [31:0] in_times_start;
	logic out_valid;
	logic out_ready;
	logic [31:0] out_block;
	logic [63:0] out_cw;
	logic [31:0] out_times;
	logic [31:0] out_times_start;
	logic [63:0] out_result;

	logic [csa_job_pkg::RES_W-1:0] exp_q [$];
	logic [csa_job_pkg::RES_W-1:0] head;
	logic [31:0] lcg_state;
	int error_count;
	int check_count;
	int out_count;
	int test_count;

	csa_clk_gen u_clk_gen (
		.rst_req_i(rst_req),
		.clk_o(clk),
		.rst_n_o(rst_n)
	);

	csa_search_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid_i(in_valid),
		.in_ready_o(in_ready),
		.in_block_i(in_block),
		.in_cw_i(in_cw),
		.in_times_i(in_times),
		.in_times_start_i(in_times_start),
		.out_valid_o(out_valid),
		.out_ready_i(out_ready),
		.out_block_o(out_block),
		.out_cw_o(out_cw),
		.out_times_o(out_times),
		.out_times_start_o(out_times_start),
		.out_result_o(out_result)
	);

	bind csa_search_top csa_search_assert u_assert (
		.clk(clk),
		.rst_n(rst_n),
		.in_ready_i(in_ready_o),
		.out_valid_i(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_data_i({out_result_o, out_times_start_o, out_times_o, out_cw_o, out_block_o})
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Block rounds and stream steps run side by side, results XORed
	function automatic logic [63:0] expected_result(input logic [63:0] cw,
		input logic [31:0] tm, input logic [31:0] ts);
		logic [63:0] blk;
		logic [63:0] nxt;
		logic [7:0] b;
		logic [31:0] hi;
		logic [31:0] lo;
		logic [31:0] tmp;
		logic [31:0] r;
		blk = cw;
		hi = cw[63:32];
		lo = cw[31:0];
		for (int unsigned i = 0; i < tm; i++) begin
			r = ts + i;
			for (int k = 0; k < 8; k++) begin
				b = blk[8*((k+1)%8) +: 8];
				nxt[8*k +: 8] = {b[4:0], b[7:5]} ^ 8'h5a ^ r[7:0];
			end
			blk = nxt;
			tmp = lo ^ {hi[26:0], hi[31:27]} ^ r;
			lo = hi;
			hi = tmp;
		end
		return blk ^ {hi, lo};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expv);
		check_count++;
		if (got !== expv) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, expv);
			error_count++;
		end
	endtask

	// in_ready is sampled at the falling edge, where it is stable
	task automatic offer_job(input logic [31:0] blk, input logic [63:0] cw,
		input logic [31:0] tm, input logic [31:0] ts, input int max_cycles,
		output bit accepted);
		int waited;
		waited = 0;
		accepted = 1'b0;
		@(negedge clk);
		in_valid = 1'b1;
		in_block = blk;
		in_cw = cw;
		in_times = tm;
		in_times_start = ts;
		while (!accepted && waited < max_cycles) begin
			accepted = in_ready;
			@(posedge clk);
			waited++;
			if (!accepted && waited < max_cycles) begin
				@(negedge clk);
			end
		end
		if (accepted) begin
			exp_q.push_back({expected_result(cw, tm, ts), ts, tm, cw, blk});
		end else begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic send_job(input logic [31:0] blk, input logic [63:0] cw,
		input logic [31:0] tm, input logic [31:0] ts);
		bit ok;
		offer_job(blk, cw, tm, ts, 200, ok);
		if (!ok) begin
			$display("%0t ns: job not accepted within 200 cycles", $time);
			error_count++;
		end
	endtask

	task automatic random_job(output logic [31:0] blk, output logic [63:0] cw,
		output logic [31:0] tm, output logic [31:0] ts);
		blk = lcg_next();
		cw[63:32] = lcg_next();
		cw[31:0] = lcg_next();
		tm = (lcg_next() >> 16) % 32'd21;
		ts = lcg_next();
	endtask

	task automatic end_input();
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Then a quiet stretch, so extra outputs get caught
	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cycles) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0t ns: %0d jobs never came out", $time, exp_q.size());
			error_count++;
			exp_q.delete();
		end
		repeat (20) @(posedge clk);
	endtask

	task automatic apply_reset(input int cycles);
		@(negedge clk);
		in_valid = 1'b0;
		rst_req = 1'b1;
		repeat (cycles) @(posedge clk);
		check_value("out_valid_o", 64'(out_valid), 64'd0);
		exp_q.delete();
		@(negedge clk);
		rst_req = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		$display("Test %0d %s: %s", test_count, name,
			(error_count == errors_before) ? "ok" : "failed");
	endtask

	// Looks just after the falling edge, once the stimulus has settled
	always @(negedge clk) begin
		#1;
		if (rst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("%0t ns: output transfer with no job pending", $time);
				error_count++;
			end else begin
				head = exp_q.pop_front();
				check_value("out_block_o", 64'(out_block), 64'(head[31:0]));
				check_value("out_cw_o", out_cw, head[95:32]);
				check_value("out_times_o", 64'(out_times), 64'(head[127:96]));
				check_value("out_times_start_o", 64'(out_times_start), 64'(head[159:128]));
				check_value("out_result_o", out_result, head[223:160]);
				out_count++;
			end
		end
	end

	initial begin
		repeat (JOB_COUNT * MAX_LATENCY + MARGIN) @(posedge clk);
		$display("Watchdog: run did not finish within %0d cycles",
			JOB_COUNT * MAX_LATENCY + MARGIN);
		$display("Done: errors found");
		$finish;
	end

	initial begin : main
		logic [31:0] b;
		logic [63:0] c;
		logic [31:0] t;
		logic [31:0] s;
		int errs;
		int base;
		int sent;
		int n;
		bit accepted;
		in_valid = 1'b0;
		in_block = '0;
		in_cw = '0;
		in_times = '0;
		in_times_start = '0;
		out_ready = 1'b1;
		rst_req = 1'b0;
		lcg_state = 32'hb734_2cce;
		error_count = 0;
		check_count = 0;
		out_count = 0;
		test_count = 0;
		wait (rst_n === 1'b1);

		errs = error_count;
		send_job(32'h0000_0007, 64'h0123_4567_89ab_cdef, 32'd5, 32'h0000_00fe);
		end_input();
		wait_drain(200);
		report_test("single job", errs);

		errs = error_count;
		send_job(32'h0000_0002, 64'hdead_beef_0bad_f00d, 32'd0, 32'h1234_5678);
		end_input();
		wait_drain(200);
		report_test("zero rounds", errs);

		errs = error_count;
		for (int i = 0; i < 20; i++) begin
			random_job(b, c, t, s);
			send_job(b, c, t, s);
		end
		end_input();
		wait_drain(2000);
		report_test("random burst", errs);

		// Output stalled until the input queue pushes back
		errs = error_count;
		base = out_count;
		sent = 0;
		@(negedge clk);
		out_ready = 1'b0;
		accepted = 1'b1;
		while (accepted && sent < 16) begin
			random_job(b, c, t, s);
			offer_job(b, c, t, s, 100, accepted);
			if (accepted) begin
				sent++;
			end
		end
		if (accepted) begin
			$display("%0t ns: in_ready_o never fell with the output stalled", $time);
			error_count++;
			end_input();
		end
		repeat (8) begin
			@(negedge clk);
			check_value("in_ready_o", 64'(in_ready), 64'd0);
			check_value("out_valid_o", 64'(out_valid), 64'd1);
		end
		@(negedge clk);
		out_ready = 1'b1;
		wait_drain(2000);
		check_value("jobs received", 64'(out_count - base), 64'(sent));
		report_test("back-pressure", errs);

		errs = error_count;
		@(negedge clk);
		out_ready = 1'b0;
		send_job(32'h0000_0011, 64'h0f0f_0f0f_f0f0_f0f0, 32'd0, 32'd0);
		send_job(32'h0000_0012, 64'h1111_2222_3333_4444, 32'd0, 32'd9);
		end_input();
		n = 0;
		while (!out_valid && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!out_valid) begin
			$display("%0t ns: out_valid_o never rose before the reset", $time);
			error_count++;
		end
		apply_reset(4);
		@(posedge clk);
		check_value("out_valid_o", 64'(out_valid), 64'd0);
		check_value("in_ready_o", 64'(in_ready), 64'd1);
		@(negedge clk);
		out_ready = 1'b1;
		random_job(b, c, t, s);
		send_job(b, c, t, s);
		end_input();
		wait_drain(200);
		report_test("reset mid-run", errs);

		$display("%0d tests, %0d checks, %0d outputs, %0d errors",
			test_count, check_count, out_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: design/csa_block_core.sv
`timescale 1ns/1ps

module csa_block_core (
	input  logic                         clk,
	input  logic                         rst_n,
	csa_job_if.core                      job,
	output logic                         res_valid_o,
	input  logic                         res_ready_i,
	output logic [csa_job_pkg::CW_W-1:0] res_o
);

	logic busy_q;
	logic done_q;
	csa_job_pkg::cw_word_u state_q;
	logic [7:0] round_q;
	logic [csa_job_pkg::WORD_W-1:0] remain_q;
	logic fire;

	function automatic logic [7:0] sbox(input logic [7:0] b);
		return ((b << csa_cipher_pkg::SBOX_ROT) | (b >> (8 - csa_cipher_pkg::SBOX_ROT)))
			^ csa_cipher_pkg::SBOX_XOR;
	endfunction

	// Byte k takes the substituted byte above it, wrapping at the top
	function automatic csa_job_pkg::cw_word_u sub_round(input csa_job_pkg::cw_word_u s,
		input logic [7:0] r);
		csa_job_pkg::cw_word_u n;
		for (int k = 0; k < 8; k++) begin
			n.bytes[k] = sbox(s.bytes[(k + 1) % 8]) ^ r;
		end
		return n;
	endfunction

	assign job.blk_ready = !busy_q && !done_q;
	assign fire = job.valid && job.blk_ready && job.str_ready && job.cmb_ready;

	assign res_valid_o = done_q;
	assign res_o = state_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else if (fire) begin
			busy_q <= job.times > 1;
			done_q <= job.times <= 1;
		end else if (busy_q && remain_q == 1) begin
			busy_q <= 1'b0;
			done_q <= 1'b1;
		end else if (done_q && res_ready_i) begin
			done_q <= 1'b0;
		end
	end

	// First round is applied while loading
	always_ff @(posedge clk) begin
		if (fire) begin
			state_q <= (job.times != 0) ? sub_round(job.cw, job.times_start[7:0]) : job.cw;
			round_q <= job.times_start[7:0] + 8'd1;
			remain_q <= job.times - 1'b1;
		end else if (busy_q) begin
			state_q <= sub_round(state_q, round_q);
			round_q <= round_q + 8'd1;
			remain_q <= remain_q - 1'b1;
		end
	end

endmodule

// File: design/csa_cipher_pkg.sv
package csa_cipher_pkg;

	// Byte substitution: rotate left, then XOR with a constant
	localparam int SBOX_ROT = 3;
	localparam logic [7:0] SBOX_XOR = 8'h5a;

	// Rotate applied to the high half in each stream step
	localparam int STREAM_ROT = 5;

endpackage

// File: design/csa_combine.sv
`timescale 1ns/1ps

module csa_combine (
	input  logic                          clk,
	input  logic                          rst_n,
	csa_job_if.capture                    job,
	input  logic                          blk_valid_i,
	output logic                          blk_ready_o,
	input  logic [csa_job_pkg::CW_W-1:0]  blk_res_i,
	input  logic                          str_valid_i,
	output logic                          str_ready_o,
	input  logic [csa_job_pkg::CW_W-1:0]  str_res_i,
	output logic                          out_valid_o,
	input  logic                          out_ready_i,
	output logic [csa_job_pkg::RES_W-1:0] out_data_o
);

	logic wait_q;
	logic [csa_job_pkg::WORD_W-1:0] block_q;
	logic [csa_job_pkg::CW_W-1:0] cw_q;
	logic [csa_job_pkg::WORD_W-1:0] times_q;
	logic [csa_job_pkg::WORD_W-1:0] tstart_q;
	logic fire;
	logic accept;

	assign job.cmb_ready = !wait_q;
	assign fire = job.valid && job.blk_ready && job.str_ready && job.cmb_ready;

	// Word goes out only once both cores have finished
	assign out_valid_o = wait_q && blk_valid_i && str_valid_i;
	assign accept = out_valid_o && out_ready_i;

	// Both cores are released together
	assign blk_ready_o = accept;
	assign str_ready_o = accept;

	// Result on top, then times_start, times, control word and block
	assign out_data_o = {blk_res_i ^ str_res_i, tstart_q, times_q, cw_q, block_q};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wait_q <= 1'b0;
		end else if (fire) begin
			wait_q <= 1'b1;
		end else if (accept) begin
			wait_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			block_q <= job.block;
			cw_q <= job.cw;
			times_q <= job.times;
			tstart_q <= job.times_start;
		end
	end

endmodule

// File: design/csa_dispatch.sv
`timescale 1ns/1ps

module csa_dispatch (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          q_valid_i,
	output logic                          q_ready_o,
	input  logic [csa_job_pkg::JOB_W-1:0] q_data_i,
	csa_job_if.issue                      job
);

	logic valid_q;
	logic [csa_job_pkg::WORD_W-1:0] block_q;
	logic [csa_job_pkg::CW_W-1:0] cw_q;
	logic [csa_job_pkg::WORD_W-1:0] times_q;
	logic [csa_job_pkg::WORD_W-1:0] tstart_q;
	logic fire;

	// All three consumers take the job in the same cycle
	assign fire = valid_q && job.blk_ready && job.str_ready && job.cmb_ready;

	// Holding register is free, or is being emptied this cycle
	assign q_ready_o = !valid_q || fire;

	assign job.valid = valid_q;
	assign job.block = block_q;
	assign job.cw = cw_q;
	assign job.times = times_q;
	assign job.times_start = tstart_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (q_valid_i && q_ready_o) begin
			valid_q <= 1'b1;
		end else if (fire) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (q_valid_i && q_ready_o) begin
			block_q <= q_data_i[csa_job_pkg::WORD_W-1:0];
			cw_q <= q_data_i[csa_job_pkg::CW_LSB +: csa_job_pkg::CW_W];
			times_q <= q_data_i[csa_job_pkg::TIMES_LSB +: csa_job_pkg::WORD_W];
			tstart_q <= q_data_i[csa_job_pkg::TSTART_LSB +: csa_job_pkg::WORD_W];
		end
	end

endmodule

// File: design/csa_job_fifo.sv
`timescale 1ns/1ps

module csa_job_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr_valid_i,
	output logic             wr_ready_o,
	input  logic [WIDTH-1:0] wr_data_i,
	output logic             rd_valid_o,
	input  logic             rd_ready_i,
	output logic [WIDTH-1:0] rd_data_o
);

	logic [WIDTH-1:0] mem_q [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(DEPTH+1)-1:0] count_q;
	logic push;
	logic pop;

	assign wr_ready_o = int'(count_q) != DEPTH;
	assign rd_valid_o = count_q != '0;
	assign rd_data_o = mem_q[rd_ptr_q];

	assign push = wr_valid_i && wr_ready_o;
	assign pop = rd_valid_o && rd_ready_i;

	always_ff @(posedge clk) begin
		if (push) begin
			mem_q[wr_ptr_q] <= wr_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// File: design/csa_job_if.sv
`timescale 1ns/1ps

interface csa_job_if;

	logic valid;
	logic [csa_job_pkg::WORD_W-1:0] block;
	csa_job_pkg::cw_word_u cw;
	logic [csa_job_pkg::WORD_W-1:0] times;
	logic [csa_job_pkg::WORD_W-1:0] times_start;

	logic blk_ready;
	logic str_ready;
	logic cmb_ready;

	modport issue (
		output valid, block, cw, times, times_start,
		input blk_ready, str_ready, cmb_ready
	);

	// Each core drives only its own ready and reads the other one
	modport core (
		input valid, cw, times, times_start, cmb_ready,
		output blk_ready, str_ready
	);

	modport capture (
		input valid, block, cw, times, times_start, blk_ready, str_ready,
		output cmb_ready
	);

endinterface

// File: design/csa_job_pkg.sv
package csa_job_pkg;

	// Width of block index, times and times_start
	localparam int WORD_W = 32;

	// Control word and result
	localparam int CW_W = 64;

	// Packed job: block, control word, times, times_start
	localparam int JOB_W = 5 * WORD_W;

	// Job plus result, seven words as the host reads them back
	localparam int RES_W = 7 * WORD_W;

	// Field offsets inside a packed job or result word
	localparam int CW_LSB = WORD_W;
	localparam int TIMES_LSB = CW_LSB + CW_W;
	localparam int TSTART_LSB = TIMES_LSB + WORD_W;
	localparam int RESULT_LSB = JOB_W;

	localparam int IN_DEPTH = 4;
	localparam int OUT_DEPTH = 4;

	// Block core works on bytes, stream core on two 32-bit halves
	typedef union packed {
		logic [7:0][7:0] bytes;
		struct packed {
			logic [WORD_W-1:0] hi;
			logic [WORD_W-1:0] lo;
		} half;
	} cw_word_u;

endpackage

// File: design/csa_search_top.sv
`timescale 1ns/1ps

module csa_search_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           in_valid_i,
	output logic                           in_ready_o,
	input  logic [csa_job_pkg::WORD_W-1:0] in_block_i,
	input  logic [csa_job_pkg::CW_W-1:0]   in_cw_i,
	input  logic [csa_job_pkg::WORD_W-1:0] in_times_i,
	input  logic [csa_job_pkg::WORD_W-1:0] in_times_start_i,
	output logic                           out_valid_o,
	input  logic                           out_ready_i,
	output logic [csa_job_pkg::WORD_W-1:0] out_block_o,
	output logic [csa_job_pkg::CW_W-1:0]   out_cw_o,
	output logic [csa_job_pkg::WORD_W-1:0] out_times_o,
	output logic [csa_job_pkg::WORD_W-1:0] out_times_start_o,
	output logic [csa_job_pkg::CW_W-1:0]   out_result_o
);

	logic [csa_job_pkg::JOB_W-1:0] in_data;
	logic q_valid;
	logic q_ready;
	logic [csa_job_pkg::JOB_W-1:0] q_data;
	logic blk_valid;
	logic blk_ready;
	logic [csa_job_pkg::CW_W-1:0] blk_res;
	logic str_valid;
	logic str_ready;
	logic [csa_job_pkg::CW_W-1:0] str_res;
	logic cmb_valid;
	logic cmb_ready;
	logic [csa_job_pkg::RES_W-1:0] cmb_data;
	logic [csa_job_pkg::RES_W-1:0] out_data;

	csa_job_if u_job_if ();

	assign in_data = {in_times_start_i, in_times_i, in_cw_i, in_block_i};

	assign out_block_o = out_data[csa_job_pkg::WORD_W-1:0];
	assign out_cw_o = out_data[csa_job_pkg::CW_LSB +: csa_job_pkg::CW_W];
	assign out_times_o = out_data[csa_job_pkg::TIMES_LSB +: csa_job_pkg::WORD_W];
	assign out_times_start_o = out_data[csa_job_pkg::TSTART_LSB +: csa_job_pkg::WORD_W];
	assign out_result_o = out_data[csa_job_pkg::RESULT_LSB +: csa_job_pkg::CW_W];

	csa_job_fifo #(
		.WIDTH(csa_job_pkg::JOB_W),
		.DEPTH(csa_job_pkg::IN_DEPTH)
	) u_in_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid_i(in_valid_i),
		.wr_ready_o(in_ready_o),
		.wr_data_i(in_data),
		.rd_valid_o(q_valid),
		.rd_ready_i(q_ready),
		.rd_data_o(q_data)
	);

	csa_dispatch u_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.q_valid_i(q_valid),
		.q_ready_o(q_ready),
		.q_data_i(q_data),
		.job(u_job_if.issue)
	);

	csa_block_core u_block_core (
		.clk(clk),
		.rst_n(rst_n),
		.job(u_job_if.core),
		.res_valid_o(blk_valid),
		.res_ready_i(blk_ready),
		.res_o(blk_res)
	);

	csa_stream_core u_stream_core (
		.clk(clk),
		.rst_n(rst_n),
		.job(u_job_if.core),
		.res_valid_o(str_valid),
		.res_ready_i(str_ready),
		.res_o(str_res)
	);

	csa_combine u_combine (
		.clk(clk),
		.rst_n(rst_n),
		.job(u_job_if.capture),
		.blk_valid_i(blk_valid),
		.blk_ready_o(blk_ready),
		.blk_res_i(blk_res),
		.str_valid_i(str_valid),
		.str_ready_o(str_ready),
		.str_res_i(str_res),
		.out_valid_o(cmb_valid),
		.out_ready_i(cmb_ready),
		.out_data_o(cmb_data)
	);

	csa_job_fifo #(
		.WIDTH(csa_job_pkg::RES_W),
		.DEPTH(csa_job_pkg::OUT_DEPTH)
	) u_out_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid_i(cmb_valid),
		.wr_ready_o(cmb_ready),
		.wr_data_i(cmb_data),
		.rd_valid_o(out_valid_o),
		.rd_ready_i(out_ready_i),
		.rd_data_o(out_data)
	);

endmodule

// File: design/csa_stream_core.sv
`timescale 1ns/1ps

module csa_stream_core (
	input  logic                         clk,
	input  logic                         rst_n,
	csa_job_if.core                      job,
	output logic                         res_valid_o,
	input  logic                         res_ready_i,
	output logic [csa_job_pkg::CW_W-1:0] res_o
);

	logic busy_q;
	logic done_q;
	csa_job_pkg::cw_word_u state_q;
	logic [csa_job_pkg::WORD_W-1:0] round_q;
	logic [csa_job_pkg::WORD_W-1:0] remain_q;
	logic fire;

	function automatic csa_job_pkg::cw_word_u stream_step(input csa_job_pkg::cw_word_u s,
		input logic [csa_job_pkg::WORD_W-1:0] r);
		csa_job_pkg::cw_word_u n;
		n.half.lo = s.half.hi;
		n.half.hi = s.half.lo
			^ ((s.half.hi << csa_cipher_pkg::STREAM_ROT)
			| (s.half.hi >> (csa_job_pkg::WORD_W - csa_cipher_pkg::STREAM_ROT)))
			^ r;
		return n;
	endfunction

	// Only an idle core takes a new job
	assign job.str_ready = !busy_q && !done_q;
	assign fire = job.valid && job.blk_ready && job.str_ready && job.cmb_ready;

	assign res_valid_o = done_q;
	assign res_o = state_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else if (fire) begin
			busy_q <= job.times > 1;
			done_q <= job.times <= 1;
		end else if (busy_q && remain_q == 1) begin
			busy_q <= 1'b0;
			done_q <= 1'b1;
		end else if (done_q && res_ready_i) begin
			done_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			state_q <= (job.times != 0) ? stream_step(job.cw, job.times_start) : job.cw;
			round_q <= job.times_start + 1'b1;
			remain_q <= job.times - 1'b1;
		end else if (busy_q) begin
			state_q <= stream_step(state_q, round_q);
			round_q <= round_q + 1'b1;
			remain_q <= remain_q - 1'b1;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the csa_tb simulation with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=csa_tb_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module csa_tb --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation reported errors"
	exit 1
fi

exit 0

// File: verilog.f
design/csa_job_pkg.sv
design/csa_cipher_pkg.sv
design/csa_job_if.sv
design/csa_job_fifo.sv
design/csa_dispatch.sv
design/csa_block_core.sv
design/csa_stream_core.sv
design/csa_combine.sv
design/csa_search_top.sv
bench/csa_clk_gen.sv
bench/csa_search_assert.sv
bench/csa_tb.sv
